//--- compile.f
+incdir+hdl
hdl/axi_pkg.sv
hdl/ls_pkg.sv
hdl/sync_fifo.sv
hdl/axi_write_engine.sv
hdl/axi_read_engine.sv
hdl/axi_master_bridge.sv
test/axi_master_bridge_assertions.sv
test/tb_axi_master_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the bridge testbench with Verilator, run it into sim.log and look for the pass line.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -Wno-fatal --top-module tb_axi_master_bridge \
    -f compile.f -o tb_axi_master_bridge \
  && ./obj_dir/tb_axi_master_bridge > sim.log 2>&1 \
  || echo "Build or simulation returned an error"

grep -qx "STATUS: PASS" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

//--- test/tb_axi_master_bridge.sv
/*
 * Testbench for the AXI4 master bridge. AXI slave model with random ready
 * delays, directed tests for writes, reads, order, back-pressure and bad ops.
 */
`timescale 1ns/1ps
`include "axi_bridge_params.svh"

module tb_axi_master_bridge
  import axi_pkg::*, ls_pkg::*;
();

  localparam int ID_SEL          = 5;
  localparam int CLK_PERIOD      = 100;  // ns.
  localparam int TEST_COUNT      = 5;
  localparam int CYCLES_PER_TEST = 400;

  logic                   aclk, aresetn;
  logic                   req_valid, req_ready, rsp_valid, rsp_ready;
  ls_req_t                req;
  logic [`LS_LINE_W-1:0]  rsp_line, line_40, line_80;  // Lines written by the tests.
  axi_addr_t              aw, ar, last_aw, last_ar;    // Last addresses seen by the slave.
  axi_w_t                 w;
  axi_b_t                 b;
  axi_r_t                 r;
  logic                   aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic                   ar_valid, ar_ready, r_valid, r_ready;
  logic [31:0]            rng_state;
  logic [`AXI_DATA_W-1:0] mem [64];                    // Slave memory, 256 bytes.
  int                     aw_count, ar_count, b_count, rlast_count;
  int                     check_count, error_count;

  axi_master_bridge #(.ID_SEL(ID_SEL)) DUT (.*);

  always #(CLK_PERIOD / 2) aclk = ~aclk;

  function automatic logic [31:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);  // Xorshift32.
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [`LS_LINE_W-1:0] rand_line();
    logic [`LS_LINE_W-1:0] l;
    for (int k = 0; k < `AXI_BEATS; k++)
      l[k*32 +: 32] = rand32();
    return l;
  endfunction

  // Word index of beat k, memory wraps every 256 bytes.
  function automatic int word_idx(input logic [`AXI_ADDR_W-1:0] addr, input int k);
    return (int'(addr[7:2]) + k) % 64;
  endfunction

  function automatic logic [`LS_LINE_W-1:0] mem_line(input logic [`AXI_ADDR_W-1:0] addr);
    logic [`LS_LINE_W-1:0] l;
    for (int k = 0; k < `AXI_BEATS; k++)
      l[k*32 +: 32] = mem[word_idx(addr, k)];      // Word k is slice k.
    return l;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks.
  task automatic check_line(input string name, input logic [`LS_LINE_W-1:0] got, exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input axi_addr_t got, exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // AXI slave responder.
  task automatic idle_cycles();
    int n;
    n = int'(rand32() % 4);                        // Ready delay of 0 to 3 cycles.
    repeat (n) @(negedge aclk);
  endtask

  task automatic serve_write();
    last_aw = aw;
    idle_cycles();
    aw_ready = 1'b1;
    @(negedge aclk);
    aw_ready = 1'b0;
    aw_count++;
    for (int k = 0; k < `AXI_BEATS; k++) begin
      while (!w_valid) @(negedge aclk);
      idle_cycles();
      check_bit("w.last", w.last, k == `AXI_BEATS - 1);
      check_bit("w.strb all ones", w.strb == '1, 1'b1);
      mem[word_idx(last_aw.addr, k)] = w.data;
      w_ready = 1'b1;                              // Beat taken at the next edge.
      @(negedge aclk);
      w_ready = 1'b0;
    end
    b       = '{id: last_aw.id, resp: 2'b00};      // OKAY.
    b_valid = 1'b1;
    while (!b_ready) @(negedge aclk);
    @(negedge aclk);
    b_valid = 1'b0;
    b_count++;
  endtask

  task automatic serve_read();
    last_ar = ar;
    idle_cycles();
    ar_ready = 1'b1;
    @(negedge aclk);
    ar_ready = 1'b0;
    ar_count++;
    for (int k = 0; k < `AXI_BEATS; k++) begin
      idle_cycles();
      r.id    = last_ar.id;
      r.data  = mem[word_idx(last_ar.addr, k)];
      r.resp  = 2'b00;
      r.last  = (k == `AXI_BEATS - 1);
      r_valid = 1'b1;
      while (!r_ready) @(negedge aclk);
      @(negedge aclk);
      r_valid = 1'b0;
    end
    rlast_count++;
  endtask

  // Writes first, so a read queued behind a write sees its data.
  initial begin
    @(posedge aresetn);
    forever begin
      @(negedge aclk);
      if (aw_valid)
        serve_write();
      else if (ar_valid)
        serve_read();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Left side.
  task automatic send_req(input ls_op_t op, input logic [`AXI_ADDR_W-1:0] addr,
                          input logic [`LS_LINE_W-1:0] line);
    req       = '{line: line, addr: addr, op: op};
    req_valid = 1'b1;
    while (!req_ready) @(negedge aclk);
    @(negedge aclk);
    req_valid = 1'b0;
  endtask

  task automatic recv_line(input string name, input logic [`LS_LINE_W-1:0] exp);
    rsp_ready = 1'b1;
    while (!rsp_valid) @(negedge aclk);
    check_line(name, rsp_line, exp);
    @(negedge aclk);
    rsp_ready = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests.
  task automatic test_reset();
    check_bit("aw_valid", aw_valid, 1'b0);
    check_bit("w_valid", w_valid, 1'b0);
    check_bit("b_ready", b_ready, 1'b0);
    check_bit("ar_valid", ar_valid, 1'b0);
    check_bit("r_ready", r_ready, 1'b0);
    check_bit("rsp_valid", rsp_valid, 1'b0);
    check_bit("req_ready", req_ready, 1'b1);
  endtask

  task automatic test_write();
    int n;
    n       = b_count;
    line_40 = rand_line();
    send_req(LS_WRITE, 32'h40, line_40);
    while (b_count == n) @(negedge aclk);         // Done at the B handshake.
    check_addr("aw", last_aw, '{id: 4'(ID_SEL), addr: 32'h40, len: 8'd7, size: 3'd2,
                                 burst: INCR});
    check_line("memory at 0x40", mem_line(32'h40), line_40);
  endtask

  task automatic test_read();
    send_req(LS_READ, 32'h40, '0);
    recv_line("rsp_line of read 0x40", line_40);
    check_addr("ar", last_ar, '{id: 4'(ID_SEL), addr: 32'h40, len: 8'd7, size: 3'd2,
                                 burst: INCR});
  endtask

  task automatic test_order();
    line_80 = rand_line();
    send_req(LS_WRITE, 32'h80, line_80);
    send_req(LS_READ, 32'h80, '0);
    send_req(LS_READ, 32'h40, '0);
    recv_line("rsp_line of read 0x80", line_80);
    recv_line("rsp_line of read 0x40", mem_line(32'h40));
    check_line("memory at 0x80", mem_line(32'h80), line_80);
  endtask

  task automatic test_backpressure();
    int n;
    n = rlast_count;
    for (int i = 0; i < 9; i++)
      send_req(LS_READ, 32'(i * 32), '0);
    while (rlast_count < n + `QUEUE_DEPTH) @(negedge aclk);  // Return queue full.
    repeat (20) begin
      @(negedge aclk);
      check_bit("ar_valid with full return queue", ar_valid, 1'b0);
    end
    for (int i = 0; i < 9; i++)
      recv_line("rsp_line under back-pressure", mem_line(32'(i * 32)));
  endtask

  task automatic test_invalid_op();
    int na, nr;
    na = aw_count;
    nr = ar_count;
    send_req(LS_NOP, 32'h00, '1);
    send_req(ls_op_t'(2'b11), 32'h00, '1);
    send_req(LS_READ, 32'hC0, '0);
    recv_line("rsp_line after invalid ops", mem_line(32'hC0));
    check_bit("no AW for invalid ops", aw_count == na, 1'b1);
    check_bit("single AR for invalid op test", ar_count == nr + 1, 1'b1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog.
  initial begin
    aclk      = 1'b0;
    aresetn   = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b0;
    aw_ready  = 1'b0;
    w_ready   = 1'b0;
    b_valid   = 1'b0;
    b         = '0;
    ar_ready  = 1'b0;
    r_valid   = 1'b0;
    r         = '0;
    rng_state = 32'd29053;
    for (int i = 0; i < 64; i++)
      mem[i] = 32'hD000_0000 | 32'(i * 4);         // Fill follows the byte address.
    repeat (5) @(negedge aclk);
    aresetn = 1'b1;
    @(negedge aclk);
    test_reset();
    test_write();
    test_read();
    test_order();
    test_backpressure();
    test_invalid_op();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    #(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
    $display("Timeout after %0d cycles, the tests did not finish",
             TEST_COUNT * CYCLES_PER_TEST);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- test/axi_master_bridge_assertions.sv
/*
 * AXI protocol assertions for the bridge top level, attached by bind.
 */
`timescale 1ns/1ps
`include "axi_bridge_params.svh"

module axi_master_bridge_assertions
  import axi_pkg::*;
(
  input logic      aclk,
  input logic      aresetn,
  input axi_addr_t aw,
  input logic      aw_valid,
  input logic      aw_ready,
  input axi_w_t    w,
  input logic      w_valid,
  input logic      w_ready,
  input axi_addr_t ar,
  input logic      ar_valid,
  input logic      ar_ready,
  input axi_r_t    r,
  input logic      r_valid,
  input logic      r_ready
);

  logic [`AXI_BEAT_IDX_W-1:0] w_beat;   // W beats taken in this burst.
  logic                       rd_busy;  // AR handshake until last R beat.

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      w_beat  <= '0;
      rd_busy <= 1'b0;
    end else begin
      if (w_valid && w_ready)
        w_beat <= w.last ? '0 : w_beat + 1'b1;
      if (ar_valid && ar_ready)
        rd_busy <= 1'b1;
      else if (r_valid && r_ready && r.last)
        rd_busy <= 1'b0;
    end
  end

  a_aw_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw)) else $error("AW dropped or changed");
  a_w_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    w_valid && !w_ready |=> $stable(w)) else $error("W payload changed while stalled");
  a_w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    w_valid && !(w_ready && w.last) |=> w_valid) else $error("W valid fell inside a burst");
  a_w_last: assert property (@(posedge aclk) disable iff (!aresetn)
    w_valid && w_ready |-> w.last == (w_beat == 3'(`AXI_LEN))) else $error("W last misplaced");
  a_aw_shape: assert property (@(posedge aclk) disable iff (!aresetn)
    aw_valid |-> aw.len == 8'(`AXI_LEN) && aw.size == 3'(`AXI_SIZE) && aw.burst == INCR)
    else $error("AW burst shape wrong");
  a_ar_shape: assert property (@(posedge aclk) disable iff (!aresetn)
    ar_valid |-> ar.len == 8'(`AXI_LEN) && ar.size == 3'(`AXI_SIZE) && ar.burst == INCR)
    else $error("AR burst shape wrong");
  a_ar_single: assert property (@(posedge aclk) disable iff (!aresetn)
    rd_busy |-> !ar_valid) else $error("AR raised while a read is in flight");

endmodule

bind axi_master_bridge axi_master_bridge_assertions u_assertions (.*);

//--- hdl/axi_master_bridge.sv
/*
 * Valid/ready to AXI4 master bridge. Request queue, write and read
 * engines sharing its head, and a return queue for read lines.
 */
`timescale 1ns/1ps
`include "axi_bridge_params.svh"

module axi_master_bridge
  import axi_pkg::*, ls_pkg::*;
#(
  parameter int ID_SEL = 0  // Master ID on AW and AR.
) (
  input  logic                  aclk,
  input  logic                  aresetn,
  // Left-side request.
  input  logic                  req_valid,
  output logic                  req_ready,
  input  ls_req_t               req,
  // Left-side return.
  output logic                  rsp_valid,
  input  logic                  rsp_ready,
  output logic [`LS_LINE_W-1:0] rsp_line,
  // AXI write.
  output axi_addr_t             aw,
  output logic                  aw_valid,
  input  logic                  aw_ready,
  output axi_w_t                w,
  output logic                  w_valid,
  input  logic                  w_ready,
  input  axi_b_t                b,
  input  logic                  b_valid,
  output logic                  b_ready,
  // AXI read.
  output axi_addr_t             ar,
  output logic                  ar_valid,
  input  logic                  ar_ready,
  input  axi_r_t                r,
  input  logic                  r_valid,
  output logic                  r_ready
);

  localparam logic [`AXI_ID_W-1:0] ID = `AXI_ID_W'(ID_SEL);

  ls_req_t               head;        // Request queue head.
  logic                  head_valid;
  logic                  head_pop;
  logic                  wr_pop;
  logic                  rd_pop;
  logic                  drop;        // Unknown operation at the head.
  logic                  ret_ready;
  logic                  ret_push;
  logic [`LS_LINE_W-1:0] ret_line;

  assign drop     = head_valid && (head.op != LS_READ) && (head.op != LS_WRITE);
  assign head_pop = wr_pop | rd_pop | drop;  // Only the matching engine pops.

  ////////////////////////////////////////////////////////////////////////////
  // Queues.
  sync_fifo #(.WIDTH($bits(ls_req_t)), .DEPTH(`QUEUE_DEPTH)) u_req_fifo (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .push      (req_valid && req_ready),
    .push_data (req),
    .ready     (req_ready),
    .pop       (head_pop),
    .pop_data  (head),
    .valid     (head_valid)
  );

  sync_fifo #(.WIDTH(`LS_LINE_W), .DEPTH(`QUEUE_DEPTH)) u_ret_fifo (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .push      (ret_push),
    .push_data (ret_line),
    .ready     (ret_ready),
    .pop       (rsp_valid && rsp_ready),
    .pop_data  (rsp_line),
    .valid     (rsp_valid)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Engines.
  axi_write_engine u_wr (
    .aclk (aclk), .aresetn (aresetn), .id (ID),
    .head (head), .head_valid (head_valid), .head_pop (wr_pop),
    .aw (aw), .aw_valid (aw_valid), .aw_ready (aw_ready),
    .w (w), .w_valid (w_valid), .w_ready (w_ready),
    .b (b), .b_valid (b_valid), .b_ready (b_ready)
  );

  axi_read_engine u_rd (
    .aclk (aclk), .aresetn (aresetn), .id (ID),
    .head (head), .head_valid (head_valid), .head_pop (rd_pop),
    .ar (ar), .ar_valid (ar_valid), .ar_ready (ar_ready),
    .r (r), .r_valid (r_valid), .r_ready (r_ready),
    .ret_ready (ret_ready), .ret_push (ret_push), .ret_line (ret_line)
  );

endmodule

//--- hdl/axi_read_engine.sv
/*
 * AXI4 read engine. Issues AR for a read at the queue head, gathers
 * eight R beats into a line and pushes it to the return queue.
 */
`timescale 1ns/1ps
`include "axi_bridge_params.svh"

module axi_read_engine
  import axi_pkg::*, ls_pkg::*;
(
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic [`AXI_ID_W-1:0]  id,          // Master ID for ARID.
  // Request queue head.
  input  ls_req_t               head,
  input  logic                  head_valid,
  output logic                  head_pop,
  // AR channel.
  output axi_addr_t             ar,
  output logic                  ar_valid,
  input  logic                  ar_ready,
  // R channel.
  input  axi_r_t                r,           // ID and response are not forwarded.
  input  logic                  r_valid,
  output logic                  r_ready,
  // Return queue.
  input  logic                  ret_ready,   // Return queue not full.
  output logic                  ret_push,
  output logic [`LS_LINE_W-1:0] ret_line
);

  logic                                    pending;   // Set from AR issue to push.
  logic                                    start;
  logic                                    ar_hs;
  logic                                    r_hs;
  logic [`AXI_ADDR_W-1:0]                  addr_q;
  logic [`AXI_BEATS-1:0][`AXI_DATA_W-1:0]  line_q;    // Assembly buffer.
  logic [`AXI_BEAT_IDX_W-1:0]              beat_idx;  // Next R slot.

  // Issue only with room in the return queue.
  assign start = head_valid && (head.op == LS_READ) && !pending && ret_ready;
  assign ar_hs = ar_valid && ar_ready;
  assign r_hs  = r_valid && r_ready;

  assign head_pop = ar_hs;
  assign ret_line = line_q;

  ////////////////////////////////////////////////////////////////////////////
  // AR channel.
  assign ar.id    = id;
  assign ar.addr  = addr_q;
  assign ar.len   = 8'(`AXI_LEN);
  assign ar.size  = 3'(`AXI_SIZE);
  assign ar.burst = INCR;

  always_ff @(posedge aclk) begin
    if (start)
      addr_q <= head.addr;
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      pending  <= 1'b0;
      ar_valid <= 1'b0;
    end else begin
      if (start) begin
        pending  <= 1'b1;
        ar_valid <= 1'b1;
      end else begin
        if (ar_hs)
          ar_valid <= 1'b0;
        if (ret_push)
          pending <= 1'b0;  // Line handed off.
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // R channel and line assembly.
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      r_ready  <= 1'b0;
      beat_idx <= '0;
      ret_push <= 1'b0;
    end else begin
      if (r_hs && r.last)
        r_ready <= 1'b0;
      else if (r_valid && pending && ret_ready)
        r_ready <= 1'b1;                       // Registered, one cycle after valid.
      if (r_hs)
        beat_idx <= r.last ? '0 : beat_idx + 1'b1;
      ret_push <= r_hs && r.last;              // Push follows the last beat.
    end
  end

  // Beat k lands in slice k.
  always_ff @(posedge aclk) begin
    if (r_hs)
      line_q[beat_idx] <= r.data;
  end

endmodule

//--- hdl/axi_write_engine.sv
/*
 * AXI4 write engine. Takes a write from the request queue head,
 * issues AW, streams eight W beats from the line buffer and waits for B.
 */
`timescale 1ns/1ps
`include "axi_bridge_params.svh"

module axi_write_engine
  import axi_pkg::*, ls_pkg::*;
(
  input  logic                 aclk,
  input  logic                 aresetn,
  input  logic [`AXI_ID_W-1:0] id,          // Master ID for AWID.
  // Request queue head.
  input  ls_req_t              head,
  input  logic                 head_valid,
  output logic                 head_pop,
  // AW channel.
  output axi_addr_t            aw,
  output logic                 aw_valid,
  input  logic                 aw_ready,
  // W channel.
  output axi_w_t               w,
  output logic                 w_valid,
  input  logic                 w_ready,
  // B channel.
  input  axi_b_t               b,           // Response fields are not forwarded.
  input  logic                 b_valid,
  output logic                 b_ready
);

  logic                                    pending;   // Burst in flight until B.
  logic                                    start;
  logic                                    aw_hs;
  logic                                    w_hs;
  logic                                    b_hs;
  logic [`AXI_ADDR_W-1:0]                  addr_q;    // Burst base address.
  logic [`AXI_BEATS-1:0][`AXI_DATA_W-1:0]  line_q;    // Line split into beats.
  logic [`AXI_BEAT_IDX_W-1:0]              beat_idx;  // Next W beat.

  assign start = head_valid && (head.op == LS_WRITE) && !pending;
  assign aw_hs = aw_valid && aw_ready;
  assign w_hs  = w_valid && w_ready;
  assign b_hs  = b_valid && b_ready;

  assign head_pop = aw_hs;  // Entry leaves the queue once AW is accepted.

  ////////////////////////////////////////////////////////////////////////////
  // AW channel. Fixed burst shape.
  assign aw.id    = id;
  assign aw.addr  = addr_q;
  assign aw.len   = 8'(`AXI_LEN);
  assign aw.size  = 3'(`AXI_SIZE);
  assign aw.burst = INCR;

  // Payload capture on start.
  always_ff @(posedge aclk) begin
    if (start) begin
      addr_q <= head.addr;
      line_q <= head.line;  // Beat k is line bits 32k upward.
    end
  end

  // Pending and AW valid.
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      pending  <= 1'b0;
      aw_valid <= 1'b0;
    end else begin
      if (start) begin
        pending  <= 1'b1;
        aw_valid <= 1'b1;
      end else begin
        if (aw_hs)
          aw_valid <= 1'b0;
        if (b_hs)
          pending <= 1'b0;  // Burst complete.
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // W channel.
  assign w.data = line_q[beat_idx];
  assign w.strb = '1;                                     // Full beats only.
  assign w.last = (beat_idx == `AXI_BEAT_IDX_W'(`AXI_LEN));

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      w_valid  <= 1'b0;
      beat_idx <= '0;
    end else begin
      if (aw_hs)
        w_valid <= 1'b1;           // Data follows the address.
      else if (w_hs && w.last)
        w_valid <= 1'b0;
      if (w_hs)
        beat_idx <= w.last ? '0 : beat_idx + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // B channel. Ready follows valid by one cycle.
  always_ff @(posedge aclk) begin
    if (!aresetn)
      b_ready <= 1'b0;
    else if (b_hs)
      b_ready <= 1'b0;
    else if (b_valid && pending)
      b_ready <= 1'b1;
  end

endmodule

//--- hdl/sync_fifo.sv
/*
 * Synchronous FIFO. Circular buffer with occupancy count, not-full and not-empty flags.
 */
`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH = 32,  // Entry width.
  parameter int DEPTH = 8    // Number of entries.
) (
  input  logic             aclk,
  input  logic             aresetn,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  output logic             ready,      // Not full.
  input  logic             pop,
  output logic [WIDTH-1:0] pop_data,
  output logic             valid       // Not empty.
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

  logic [WIDTH-1:0] mem [DEPTH];  // Storage, no reset.
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;        // Entries held.
  logic             do_push;
  logic             do_pop;

  assign ready    = (count != CNT_W'(DEPTH));
  assign valid    = (count != '0);
  assign do_push  = push && ready;  // Push into a full queue is ignored.
  assign do_pop   = pop && valid;   // Same for pop on empty.
  assign pop_data = mem[rd_ptr];    // Head is visible without a pop.

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and count.
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;  // Wrap at the end.
      if (do_pop)
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;       // Both or neither, level unchanged.
      endcase
    end
  end

  // Entry write.
  always_ff @(posedge aclk) begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

endmodule

//--- hdl/ls_pkg.sv
/*
 * Left-side request types. Operation code and the request queue entry.
 */
`include "axi_bridge_params.svh"

package ls_pkg;

  // Request operation. Codes outside read and write are dropped at the queue head.
  typedef enum logic [1:0] {
    LS_NOP   = 2'b00,
    LS_READ  = `OP_READ,
    LS_WRITE = `OP_WRITE
  } ls_op_t;

  // Request queue entry, 290 bits.
  typedef struct packed {
    logic [`LS_LINE_W-1:0]  line;   // Write data, ignored on reads.
    logic [`AXI_ADDR_W-1:0] addr;   // Line base address.
    ls_op_t                 op;
  } ls_req_t;

endpackage

//--- hdl/axi_pkg.sv
/*
 * AXI4 channel payloads. One struct per channel, address struct shared by AW and AR.
 */
`include "axi_bridge_params.svh"

package axi_pkg;

  // AxBURST encoding.
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_t;

  // AW and AR request fields, 49 bits.
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;   // First beat address.
    logic [7:0]             len;    // Beats minus one.
    logic [2:0]             size;   // Log2 of bytes per beat.
    burst_t                 burst;
  } axi_addr_t;

  // W beat, 37 bits.
  typedef struct packed {
    logic [`AXI_DATA_W-1:0]   data;
    logic [`AXI_DATA_W/8-1:0] strb; // One bit per byte lane.
    logic                     last;
  } axi_w_t;

  // B response.
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_RESP_W-1:0] resp;
  } axi_b_t;

  // R beat, 39 bits.
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_RESP_W-1:0] resp;
    logic                   last;   // Final beat of the burst.
  } axi_r_t;

endpackage

//--- hdl/axi_bridge_params.svh
/*
 * Bridge parameters. Widths, burst shape, queue depth and operation codes.
 */
`ifndef AXI_BRIDGE_PARAMS_SVH
`define AXI_BRIDGE_PARAMS_SVH

// AXI channel widths.
`define AXI_ADDR_W      32  // Byte address.
`define AXI_DATA_W      32  // One beat.
`define AXI_ID_W        4   // Transaction ID.
`define AXI_RESP_W      2   // BRESP and RRESP.

// Left-side line.
`define LS_LINE_W       256 // One request line.

// Burst shape, one line per burst.
`define AXI_BEATS       8   // Beats per burst.
`define AXI_BEAT_IDX_W  3   // Beat counter width.
`define AXI_LEN         7   // AxLEN, beats minus one.
`define AXI_SIZE        2   // AxSIZE, four bytes per beat.

// Request and return queue depth.
`define QUEUE_DEPTH     8

// Operation codes carried with each request.
`define OP_READ         2'b01
`define OP_WRITE        2'b10

`endif
